// File: project.f
+incdir+hw
hw/cpu_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/control.sv
hw/cpu_top.sv
dv/tb_mem.sv
dv/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := hw/cpu_macros.svh hw/cpu_pkg.sv hw/alu.sv hw/reg_file.sv hw/control.sv \
        hw/cpu_top.sv dv/tb_mem.sv dv/cpu_tb.sv

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) project.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam logic [2:0] SP = 3'(`CPU_SP_REG);

    logic        clk;
    logic        reset_i;
    logic        start_i;
    logic [31:0] mem_rdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_rd;
    logic        mem_wr;
    logic        halted;

    logic [31:0] regs [8];
    logic [31:0] shadow [1024];
    bit          exec_reads [1024];
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    int          pc = 0;
    int          n_instr = 0;
    int          cycle = 0;
    int          daddr = 0;
    int          seq_errors = 0;
    bit          run = 0;
    bit          reset_seen = 0;
    bit          built = 0;
    bit          done = 0;

    opcode_e reg_ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
    opcode_e imm_ops [7] = '{OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_XORI, OP_SHLI, OP_SHRI};

    cpu_top dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .halted_o    (halted)
    );

    tb_mem u_mem (
        .clk     (clk),
        .cycle_i (cycle),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .wr_i    (mem_wr),
        .rdata_o (mem_rdata)
    );

    function automatic logic [31:0] enc(input opcode_e op, input cond_e c, input logic s,
                                        input logic [2:0] rd, input logic [2:0] ra,
                                        input logic [15:0] low);
        return {op, c, s, rd, ra, low};
    endfunction

    function automatic logic [31:0] model_alu(input opcode_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB, OP_SUBI: return a - b;
            OP_AND, OP_ANDI: return a & b;
            OP_OR, OP_ORI:   return a | b;
            OP_XOR, OP_XORI: return a ^ b;
            OP_SHL, OP_SHLI: return a << b[4:0];
            OP_SHR, OP_SHRI: return a >> b[4:0];
            default:         return a;
        endcase
    endfunction

    // flags only ever come from a subtract, so conditions are plain comparisons
    function automatic bit cond_holds(input cond_e c);
        case (c)
            EQ:      return cmp_a == cmp_b;
            NE:      return cmp_a != cmp_b;
            LTU:     return cmp_a < cmp_b;
            GTU:     return cmp_a > cmp_b;
            LEU:     return cmp_a <= cmp_b;
            GEU:     return cmp_a >= cmp_b;
            LTS:     return $signed(cmp_a) < $signed(cmp_b);
            GTS:     return $signed(cmp_a) > $signed(cmp_b);
            LES:     return $signed(cmp_a) <= $signed(cmp_b);
            GES:     return $signed(cmp_a) >= $signed(cmp_b);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [15:0] rnd16();
        return 16'($urandom);
    endfunction

    task automatic emit(input logic [31:0] w, input bit reads);
        u_mem.load_word(pc, w);
        exec_reads[pc] = reads;
        pc++;
    endtask

    // a write is due in the execute cycle of the instruction about to be emitted
    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        u_mem.expect_write(addr, data, 2 * pc + 1);
        shadow[addr[9:0]] = data;
    endtask

    task automatic ldi(input logic [2:0] rd, input logic [15:0] imm, input cond_e c);
        emit(enc(OP_LDI, c, 1'b0, rd, 3'd0, imm), 1'b0);
        if (cond_holds(c)) begin
            regs[rd] = {16'h0, imm};
        end
    endtask

    task automatic op_r(input opcode_e op, input logic [2:0] rd, input logic [2:0] ra,
                        input logic [2:0] rb, input logic s);
        emit(enc(op, NONE, s, rd, ra, {rb, 13'h0}), 1'b0);
        if (s) begin
            cmp_a = regs[ra];
            cmp_b = regs[rb];
        end
        regs[rd] = model_alu(op, regs[ra], regs[rb]);
    endtask

    task automatic op_i(input opcode_e op, input logic [2:0] rd, input logic [2:0] ra,
                        input logic [15:0] imm, input logic s);
        emit(enc(op, NONE, s, rd, ra, imm), 1'b0);
        if (s) begin
            cmp_a = regs[ra];
            cmp_b = {16'h0, imm};
        end
        regs[rd] = model_alu(op, regs[ra], {16'h0, imm});
    endtask

    task automatic st(input logic [2:0] rd, input logic [15:0] addr);
        expect_store({16'h0, addr}, regs[rd]);
        emit(enc(OP_ST, NONE, 1'b0, rd, 3'd0, addr), 1'b0);
    endtask

    task automatic str(input logic [2:0] rd, input logic [2:0] rb);
        expect_store(regs[rb], regs[rd]);
        emit(enc(OP_STR, NONE, 1'b0, rd, 3'd0, {rb, 13'h0}), 1'b0);
    endtask

    task automatic ldr(input logic [2:0] rd, input logic [2:0] rb);
        emit(enc(OP_LDR, NONE, 1'b0, rd, 3'd0, {rb, 13'h0}), 1'b1);
        regs[rd] = shadow[regs[rb][9:0]];
    endtask

    task automatic push(input logic [2:0] rd);
        regs[SP] = regs[SP] - 32'd1;
        expect_store(regs[SP], regs[rd]);
        emit(enc(OP_PUSH, NONE, 1'b0, rd, 3'd0, 16'h0), 1'b0);
    endtask

    task automatic pop(input logic [2:0] rd);
        emit(enc(OP_POP, NONE, 1'b0, rd, 3'd0, 16'h0), 1'b1);
        regs[rd] = shadow[regs[SP][9:0]];
        regs[SP] = regs[SP] + 32'd1;
    endtask

    task automatic mov(input logic [2:0] rd, input logic [2:0] ra);
        emit(enc(OP_MOV, NONE, 1'b0, rd, ra, 16'h0), 1'b0);
        regs[rd] = regs[ra];
    endtask

    // old value 0xAAAA survives only when the condition fails
    task automatic cond_sweep();
        for (int c = 0; c <= 10; c++) begin
            ldi(3'd4, 16'hAAAA, NONE);
            ldi(3'd4, 16'h5555, cond_e'(c));
            st(3'd4, 16'(daddr));
            daddr++;
        end
    endtask

    task automatic build_program();
        logic [15:0] lhs [3];
        logic [15:0] rhs [3];
        lhs = '{16'd5, 16'd9, 16'd3};
        rhs = '{16'd5, 16'd3, 16'd9};
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        // ALU operations, register and immediate forms
        for (int k = 0; k < 7; k++) begin
            ldi(3'd1, rnd16(), NONE);
            op_i(OP_SHLI, 3'd1, 3'd1, 16'(k * 3), 1'b0);
            ldi(3'd2, rnd16(), NONE);
            op_r(reg_ops[k], 3'd3, 3'd1, 3'd2, 1'b0);
            st(3'd3, 16'(16'h0300 + 2 * k));
            op_i(imm_ops[k], 3'd4, 3'd1, rnd16(), 1'b0);
            st(3'd4, 16'(16'h0301 + 2 * k));
        end
        // condition codes after a flag-setting subtract
        daddr = 'h320;
        for (int p = 0; p < 3; p++) begin
            ldi(3'd1, lhs[p], NONE);
            op_i(OP_SUBI, 3'd2, 3'd1, rhs[p], 1'b1);
            cond_sweep();
        end
        op_r(OP_ADD, 3'd5, 3'd1, 3'd1, 1'b0);
        cond_sweep();
        // signed overflow case
        ldi(3'd1, 16'h8000, NONE);
        op_i(OP_SHLI, 3'd1, 3'd1, 16'd16, 1'b0);
        op_i(OP_SUBI, 3'd2, 3'd1, 16'd1, 1'b1);
        cond_sweep();
        // stack and indirect access
        ldi(SP, 16'h0200, NONE);
        ldi(3'd1, rnd16(), NONE);
        ldi(3'd2, rnd16(), NONE);
        push(3'd1);
        push(3'd2);
        pop(3'd3);
        ldi(3'd5, 16'h01FF, NONE);
        ldr(3'd4, 3'd5);
        st(3'd3, 16'h0360);
        st(3'd4, 16'h0361);
        ldi(3'd5, 16'h0362, NONE);
        str(3'd3, 3'd5);
        mov(3'd0, 3'd4);
        st(3'd0, 16'h0363);
        emit(enc(OP_HALT, NONE, 1'b0, 3'd0, 3'd0, 16'h0), 1'b0);
        n_instr = pc;
        built = 1;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cycle 2i fetches instruction i, cycle 2i+1 executes it
    always @(posedge clk) begin
        if (reset_i) begin
            reset_seen <= 1'b1;
        end
        if (reset_seen && !run) begin
            assert (mem_rd === 1'b0 && mem_wr === 1'b0 && halted === 1'b0)
            else begin
                $display("Fail %0t: memory strobe or halt active before start", $time);
                seq_errors++;
            end
        end else if (run && cycle < 2 * n_instr) begin
            if (cycle % 2 == 0) begin
                assert (mem_rd === 1'b1 && mem_wr === 1'b0 && mem_addr == 32'(cycle / 2))
                else begin
                    $display("Fail %0t: fetch %0d missing or at wrong address %h",
                             $time, cycle / 2, mem_addr);
                    seq_errors++;
                end
            end else begin
                assert (mem_rd === exec_reads[cycle / 2])
                else begin
                    $display("Fail %0t: read strobe wrong in execute of %0d", $time, cycle / 2);
                    seq_errors++;
                end
            end
            assert (halted === 1'b0)
            else begin
                $display("Fail %0t: halted before the HALT instruction", $time);
                seq_errors++;
            end
        end else if (run) begin
            assert (halted === 1'b1 && mem_rd === 1'b0 && mem_wr === 1'b0)
            else begin
                $display("Fail %0t: core active or not halted after HALT", $time);
                seq_errors++;
            end
        end
        if (start_i && !run) begin
            run   <= 1'b1;
            cycle <= 0;
        end else if (run) begin
            cycle <= cycle + 1;
        end
    end

    initial begin
        wait (built);
        repeat (8 + 4 * n_instr + 100) @(posedge clk);
        if (!done) begin
            $display("timeout: the core never halted within %0d instructions", n_instr);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        reset_i = 1'b1;
        start_i = 1'b0;
        void'($urandom(64));
        repeat (8) @(negedge clk);
        build_program();
        reset_i = 1'b0;
        @(negedge clk);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        wait (halted === 1'b1);
        repeat (10) @(negedge clk);
        done = 1;
        assert (u_mem.pending() == 0)
        else begin
            $display("%0d expected writes never reached memory", u_mem.pending());
            seq_errors++;
        end
        $display("errors: write %0d, sequence %0d", u_mem.errors, seq_errors);
        if (u_mem.errors == 0 && seq_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dv/tb_mem.sv
`timescale 1ns/10ps

module tb_mem (
    input  logic        clk,
    input  int          cycle_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic        wr_i,
    output logic [31:0] rdata_o
);
    localparam int WORDS = 1024;

    logic [31:0] mem [WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_cycle [$];
    int          errors = 0;

    // fill pattern depends on every address bit
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'hA5A5_0000;
        end
    end

    assign rdata_o = mem[addr_i[9:0]];

    task automatic load_word(input int addr, input logic [31:0] data);
        mem[addr] = data;
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [31:0] data, input int cyc);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_cycle.push_back(cyc);
    endtask

    function automatic int pending();
        return exp_addr.size();
    endfunction

    always @(posedge clk) begin
        if (wr_i) begin
            assert (exp_addr.size() > 0)
            else begin
                $display("unexpected memory write to %h at time %0t", addr_i, $time);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                assert (addr_i == exp_addr[0] && wdata_i == exp_data[0]
                        && cycle_i == exp_cycle[0])
                else begin
                    $display("Fail %0t: write %h <- %h in cycle %0d, expected %h <- %h in cycle %0d",
                             $time, addr_i, wdata_i, cycle_i,
                             exp_addr[0], exp_data[0], exp_cycle[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_cycle.pop_front());
            end
            // the core never reads in a write cycle
            mem[addr_i[9:0]] = wdata_i;
        end
    end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_top (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 start_i,
    input  logic [`CPU_XLEN-1:0] mem_rdata_i,
    output logic [`CPU_XLEN-1:0] mem_addr_o,
    output logic [`CPU_XLEN-1:0] mem_wdata_o,
    output logic                 mem_rd_o,
    output logic                 mem_wr_o,
    output logic                 halted_o
);
    import cpu_pkg::*;

    localparam int XLEN = `CPU_XLEN;

    instr_u          ir;
    status_t         status;
    status_t         alu_status;
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wdata;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ir     <= '0;
            status <= '0;
        end else begin
            if (ctrl.ld_ir) begin
                ir <= mem_rdata_i;
            end
            if (ctrl.ld_status) begin
                status <= alu_status;
            end
        end
    end

    assign imm = {{(XLEN-16){1'b0}}, ir.iform.imm16};

    // operand, address and write-back selects
    assign alu_a      = ctrl.a_from_imm ? imm : rdata_a;
    assign alu_b      = ctrl.b_from_imm ? imm : rdata_b;
    assign mem_addr_o = ctrl.addr_from_imm ? imm : rdata_b;
    assign wdata      = ctrl.wdata_from_b ? mem_rdata_i : alu_result;

    assign mem_wdata_o = rdata_a;
    assign mem_rd_o    = ctrl.mem_rd;
    assign mem_wr_o    = ctrl.mem_wr;

    control u_control (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (start_i),
        .instr_i  (ir),
        .status_i (status),
        .ctrl_o   (ctrl),
        .halted_o (halted_o)
    );

    reg_file u_reg_file (
        .clk            (clk),
        .reset_i        (reset_i),
        .sel_a_i        (ctrl.sel_a),
        .sel_b_i        (ctrl.sel_b),
        .sel_wr_i       (ctrl.sel_wr),
        .ld_i           (ctrl.ld_reg),
        .wdata_i        (wdata),
        .count_b_i      (ctrl.count_b),
        .pre_count_b_i  (ctrl.pre_count_b),
        .post_count_b_i (ctrl.post_count_b),
        .rdata_a_o      (rdata_a),
        .rdata_b_o      (rdata_b)
    );

    alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result),
        .status_o (alu_status)
    );

endmodule

// File: hw/control.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module control (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             start_i,
    input  cpu_pkg::instr_u  instr_i,
    input  cpu_pkg::status_t status_i,
    output cpu_pkg::ctrl_t   ctrl_o,
    output logic             halted_o
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {IDLE, FETCH, EXECUTE, STOPPED} state_e;

    state_e   state;
    opcode_e  opcode;
    reg_num_t rd;
    reg_num_t ra;
    reg_num_t rb;
    logic     cond_ok;

    function automatic logic cond_met(input cond_e cond, input status_t st);
        case (cond)
            NONE:    return 1'b1;
            EQ:      return st.zero;
            NE:      return !st.zero;
            LTU:     return !st.carry;
            GTU:     return st.carry && !st.zero;
            LEU:     return !st.carry || st.zero;
            GEU:     return st.carry;
            LTS:     return st.negative != st.overflow;
            GTS:     return !st.zero && (st.negative == st.overflow);
            LES:     return st.zero || (st.negative != st.overflow);
            GES:     return st.negative == st.overflow;
            default: return 1'b1;
        endcase
    endfunction

    function automatic alu_op_e alu_op_for(input opcode_e op);
        case (op)
            OP_ADD, OP_ADDI: return ALU_ADD;
            OP_SUB, OP_SUBI: return ALU_SUB;
            OP_AND, OP_ANDI: return ALU_AND;
            OP_OR, OP_ORI:   return ALU_OR;
            OP_XOR, OP_XORI: return ALU_XOR;
            OP_SHL, OP_SHLI: return ALU_SHL;
            OP_SHR, OP_SHRI: return ALU_SHR;
            default:         return ALU_PASSA;
        endcase
    endfunction

    assign opcode  = instr_i.rform.opcode;
    assign rd      = instr_i.rform.rd;
    assign ra      = instr_i.rform.ra;
    assign rb      = instr_i.rform.rb;
    assign cond_ok = cond_met(instr_i.rform.cond, status_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state <= FETCH;
                    end
                end
                FETCH:   state <= EXECUTE;
                EXECUTE: state <= (cond_ok && opcode == OP_HALT) ? STOPPED : FETCH;
                default: state <= STOPPED;
            endcase
        end
    end

    assign halted_o = (state == STOPPED);

    always_comb begin
        ctrl_o = '0;
        case (state)
            FETCH: begin
                // ir <- mem[pc++]
                ctrl_o.sel_b        = reg_num_t'(`CPU_PC_REG);
                ctrl_o.count_b      = 2'sd1;
                ctrl_o.post_count_b = 1'b1;
                ctrl_o.mem_rd       = 1'b1;
                ctrl_o.ld_ir        = 1'b1;
            end
            EXECUTE: begin
                // a failed condition turns the instruction into a nop
                if (cond_ok) begin
                    case (opcode)
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
                        OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_XORI, OP_SHLI, OP_SHRI: begin
                            ctrl_o.sel_a      = ra;
                            ctrl_o.sel_b      = rb;
                            ctrl_o.b_from_imm = opcode inside {OP_ADDI, OP_SUBI, OP_ANDI,
                                                               OP_ORI, OP_XORI, OP_SHLI,
                                                               OP_SHRI};
                            ctrl_o.alu_op     = alu_op_for(opcode);
                            ctrl_o.sel_wr     = rd;
                            ctrl_o.ld_reg     = 1'b1;
                            ctrl_o.ld_status  = instr_i.rform.set_status;
                        end
                        OP_LDI, OP_MOV: begin
                            ctrl_o.sel_a      = ra;
                            ctrl_o.a_from_imm = (opcode == OP_LDI);
                            ctrl_o.alu_op     = ALU_PASSA;
                            ctrl_o.sel_wr     = rd;
                            ctrl_o.ld_reg     = 1'b1;
                            ctrl_o.ld_status  = instr_i.rform.set_status;
                        end
                        OP_LD, OP_LDR: begin
                            ctrl_o.sel_b         = rb;
                            ctrl_o.addr_from_imm = (opcode == OP_LD);
                            ctrl_o.mem_rd        = 1'b1;
                            ctrl_o.wdata_from_b  = 1'b1;
                            ctrl_o.sel_wr        = rd;
                            ctrl_o.ld_reg        = 1'b1;
                        end
                        // stored value comes from rd, like push
                        OP_ST, OP_STR: begin
                            ctrl_o.sel_a         = rd;
                            ctrl_o.sel_b         = rb;
                            ctrl_o.addr_from_imm = (opcode == OP_ST);
                            ctrl_o.mem_wr        = 1'b1;
                        end
                        // mem[--sp] <- rd
                        OP_PUSH: begin
                            ctrl_o.sel_a       = rd;
                            ctrl_o.sel_b       = reg_num_t'(`CPU_SP_REG);
                            ctrl_o.count_b     = -2'sd1;
                            ctrl_o.pre_count_b = 1'b1;
                            ctrl_o.mem_wr      = 1'b1;
                        end
                        // rd <- mem[sp++]
                        OP_POP: begin
                            ctrl_o.sel_b        = reg_num_t'(`CPU_SP_REG);
                            ctrl_o.count_b      = 2'sd1;
                            ctrl_o.post_count_b = 1'b1;
                            ctrl_o.mem_rd       = 1'b1;
                            ctrl_o.wdata_from_b = 1'b1;
                            ctrl_o.sel_wr       = rd;
                            ctrl_o.ld_reg       = 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
            end
            default: begin
            end
        endcase
    end

    // one shared memory port, so a cycle is either a read or a write
    assert property (@(posedge clk) disable iff (reset_i) !(ctrl_o.mem_rd && ctrl_o.mem_wr));

    // only reset brings the core out of STOPPED
    assert property (@(posedge clk) halted_o && !reset_i |=> halted_o);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 reset_i,
    input  cpu_pkg::reg_num_t    sel_a_i,
    input  cpu_pkg::reg_num_t    sel_b_i,
    input  cpu_pkg::reg_num_t    sel_wr_i,
    input  logic                 ld_i,
    input  logic [`CPU_XLEN-1:0] wdata_i,
    input  logic signed [1:0]    count_b_i,
    input  logic                 pre_count_b_i,
    input  logic                 post_count_b_i,
    output logic [`CPU_XLEN-1:0] rdata_a_o,
    output logic [`CPU_XLEN-1:0] rdata_b_o
);
    import cpu_pkg::*;

    localparam int XLEN = `CPU_XLEN;

    logic [XLEN-1:0] regs [`CPU_NREGS];
    logic [XLEN-1:0] step;
    logic [XLEN-1:0] b_adjusted;
    logic            count_en;

    // sign-extended count step
    assign step       = XLEN'(count_b_i);
    assign b_adjusted = regs[sel_b_i] + step;
    assign count_en   = pre_count_b_i || post_count_b_i;

    assign rdata_a_o = regs[sel_a_i];
    // pre-count shows the new value now, post-count the old one
    assign rdata_b_o = pre_count_b_i ? b_adjusted : regs[sel_b_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int n = 0; n < `CPU_NREGS; n++) begin
                regs[n] <= '0;
            end
        end else begin
            for (int n = 0; n < `CPU_NREGS; n++) begin
                if (ld_i && sel_wr_i == reg_num_t'(n)) begin
                    regs[n] <= wdata_i;
                end else if (count_en && sel_b_i == reg_num_t'(n)) begin
                    regs[n] <= b_adjusted;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset_i) !(pre_count_b_i && post_count_b_i));

endmodule

// File: hw/alu.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module alu (
    input  cpu_pkg::alu_op_e     op_i,
    input  logic [`CPU_XLEN-1:0] a_i,
    input  logic [`CPU_XLEN-1:0] b_i,
    output logic [`CPU_XLEN-1:0] result_o,
    output cpu_pkg::status_t     status_o
);
    import cpu_pkg::*;

    localparam int XLEN = `CPU_XLEN;
    localparam int SHW  = $clog2(XLEN);

    logic            sub;
    logic [XLEN-1:0] b_eff;
    logic [XLEN:0]   sum;

    // a - b as a + ~b + 1, so carry out is the no-borrow flag
    assign sub   = (op_i == ALU_SUB);
    assign b_eff = sub ? ~b_i : b_i;
    assign sum   = {1'b0, a_i} + {1'b0, b_eff} + {{XLEN{1'b0}}, sub};

    always_comb begin
        result_o          = '0;
        status_o.carry    = 1'b0;
        status_o.overflow = 1'b0;
        case (op_i)
            ALU_PASSA: result_o = a_i;
            ALU_ADD, ALU_SUB: begin
                result_o          = sum[XLEN-1:0];
                status_o.carry    = sum[XLEN];
                status_o.overflow = (a_i[XLEN-1] == b_eff[XLEN-1])
                                 && (sum[XLEN-1] != a_i[XLEN-1]);
            end
            ALU_AND:   result_o = a_i & b_i;
            ALU_OR:    result_o = a_i | b_i;
            ALU_XOR:   result_o = a_i ^ b_i;
            ALU_SHL:   result_o = a_i << b_i[SHW-1:0];
            ALU_SHR:   result_o = a_i >> b_i[SHW-1:0];
            default:   result_o = a_i;
        endcase
        status_o.zero     = (result_o == '0);
        status_o.negative = result_o[XLEN-1];
    end

endmodule

// File: hw/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_num_t;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDI,
        OP_SUB,
        OP_SUBI,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_SHL,
        OP_SHLI,
        OP_SHR,
        OP_SHRI,
        OP_LDI,
        OP_LD,
        OP_LDR,
        OP_ST,
        OP_STR,
        OP_PUSH,
        OP_POP,
        OP_MOV,
        OP_HALT
    } opcode_e;

    typedef enum logic [3:0] {
        NONE, EQ, NE, LTU, GTU, LEU, GEU, LTS, GTS, LES, GES
    } cond_e;

    typedef enum logic [2:0] {
        ALU_PASSA, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR
    } alu_op_e;

    // carry after a subtract means no borrow
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } status_t;

    typedef struct packed {
        opcode_e    opcode;
        cond_e      cond;
        logic       set_status;
        reg_num_t   rd;
        reg_num_t   ra;
        reg_num_t   rb;
        logic [12:0] pad;
    } instr_reg_t;

    // imm16 is zero-extended wherever it is used
    typedef struct packed {
        opcode_e     opcode;
        cond_e       cond;
        logic        set_status;
        reg_num_t    rd;
        reg_num_t    ra;
        logic [15:0] imm16;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t rform;
        instr_imm_t iform;
    } instr_u;

    typedef struct packed {
        reg_num_t          sel_a;
        reg_num_t          sel_b;
        reg_num_t          sel_wr;
        logic              ld_reg;
        logic              ld_status;
        logic              ld_ir;
        logic              a_from_imm;
        logic              b_from_imm;
        logic              addr_from_imm;
        logic signed [1:0] count_b;
        logic              pre_count_b;
        logic              post_count_b;
        // write-back from memory read data instead of the ALU
        logic              wdata_from_b;
        alu_op_e           alu_op;
        logic              mem_rd;
        logic              mem_wr;
    } ctrl_t;

endpackage

// File: hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and memory word width
`define CPU_XLEN 32

// register file size, register numbers are $clog2 of this
`define CPU_NREGS 8

// registers with a fixed role
`define CPU_SP_REG 6
`define CPU_PC_REG 7

`endif
